/* list.f */
+incdir+include
hw/mips_isa_pkg.sv
hw/lsu_bus_pkg.sv
hw/mips_cpu_memint.sv
hw/lsu_store_align.sv
hw/lsu_load_merge.sv
hw/lsu_ctrl.sv
hw/mips_lsu.sv
test/wb_mem_model.sv
test/tb_mips_lsu.sv

/* run.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator, then scan the log
rm -f sim.log
{ verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_lsu \
      -f list.f --Mdir obj_dir \
  && ./obj_dir/Vtb_mips_lsu; } > sim.log 2>&1 \
  || echo "test failed" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

/* test/tb_mips_lsu.sv */
`default_nettype none

`include "lsu_defines.svh"

module tb_mips_lsu;
    timeunit 1ns;
    timeprecision 100ps;

    import mips_isa_pkg::*;

    localparam int N_REQ      = 300;
    localparam int MAX_CYCLES = N_REQ * 8 + 200;

    logic                   clk;
    logic                   rst;
    logic                   start;
    opcode_e                op;
    instr_type_e            instr_type;
    logic [`LSU_DATA_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] store_data;
    logic [`LSU_DATA_W-1:0] reg_old;
    logic                   busy;
    logic                   done;
    logic                   misaligned;
    logic [`LSU_DATA_W-1:0] result;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`LSU_DATA_W-1:0] wb_adr;
    logic [`LSU_BYTES-1:0]  wb_sel;
    logic [`LSU_DATA_W-1:0] wb_dat_w;
    logic [`LSU_DATA_W-1:0] wb_dat_r;
    logic                   wb_ack;

    logic [31:0] shadow [64];
    logic [31:0] rng;
    int          errors;
    int          cycles;
    int          cyc_count;
    int          bus_total;
    logic        cyc_prev;

    // Expected values of the request in flight
    logic [31:0] exp_adr;
    logic [3:0]  exp_sel;
    logic        exp_we;
    logic [31:0] exp_result;
    logic        exp_mis;
    int          exp_cycles;
    logic [5:0]  chk_idx;
    logic [31:0] exp_word;

    mips_lsu mips_lsu_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .instr_type (instr_type),
        .addr       (addr),
        .store_data (store_data),
        .reg_old    (reg_old),
        .busy       (busy),
        .done       (done),
        .misaligned (misaligned),
        .result     (result),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_sel     (wb_sel),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    wb_mem_model mem_inst (
        .clk   (clk),
        .rst   (rst),
        .cyc   (wb_cyc),
        .stb   (wb_stb),
        .we    (wb_we),
        .adr   (wb_adr),
        .sel   (wb_sel),
        .dat_w (wb_dat_w),
        .dat_r (wb_dat_r),
        .ack   (wb_ack)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic opcode_e pick_op(input int n);
        case (n)
            0:       return LB;
            1:       return LBU;
            2:       return LH;
            3:       return LHU;
            4:       return LW;
            5:       return LWL;
            6:       return LWR;
            7:       return SB;
            8:       return SH;
            9:       return SW;
            default: return LUI;
        endcase
    endfunction

    function automatic logic reads_mem(input opcode_e o);
        return o == LB || o == LBU || o == LH || o == LHU || o == LW || o == LWL || o == LWR;
    endfunction

    function automatic logic writes_mem(input opcode_e o);
        return o == SB || o == SH || o == SW;
    endfunction

    // Lane rules of the address decoder
    function automatic logic [3:0] lane_mask(input opcode_e o, input logic [1:0] k);
        logic [3:0] m;
        m = 4'b0000;
        for (int j = 0; j < 4; j++) begin
            case (o)
                LB, LBU, SB: m[j] = (j == k);
                LH, LHU, SH: m[j] = !k[0] && (j == k || j == k + 1);
                LWL:         m[j] = (j >= k);
                LWR:         m[j] = (j <= k);
                default:     m[j] = 1'b1;
            endcase
        end
        return m;
    endfunction

    function automatic logic [31:0] load_expect(input opcode_e o, input logic [1:0] k,
                                                input logic [31:0] m, input logic [31:0] old);
        logic [31:0] sh;
        logic [31:0] r;
        sh = m >> (8 * k);
        r  = old;
        case (o)
            LB:  r = {{24{sh[7]}}, sh[7:0]};
            LBU: r = {24'h0, sh[7:0]};
            LH:  r = {{16{sh[15]}}, sh[15:0]};
            LHU: r = {16'h0, sh[15:0]};
            LW:  r = m;
            default: begin
                for (int j = 0; j < 4; j++) begin
                    if ((o == LWL && j >= k) || (o == LWR && j <= k)) begin
                        r[8*j +: 8] = m[8*j +: 8];
                    end
                end
            end
        endcase
        return r;
    endfunction

    // Replicated store data lands on the enabled lanes only
    function automatic logic [31:0] store_expect(input opcode_e o, input logic [3:0] lanes,
                                                 input logic [31:0] m, input logic [31:0] sd);
        logic [31:0] rep;
        logic [31:0] r;
        case (o)
            SB:      rep = {4{sd[7:0]}};
            SH:      rep = {2{sd[15:0]}};
            default: rep = sd;
        endcase
        r = m;
        for (int j = 0; j < 4; j++) begin
            if (lanes[j]) begin
                r[8*j +: 8] = rep[8*j +: 8];
            end
        end
        return r;
    endfunction

    task automatic note_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        errors++;
        $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    task automatic run_request();
        opcode_e     o;
        instr_type_e t;
        logic [1:0]  k;
        logic [5:0]  w;
        logic [31:0] sd;
        logic [31:0] old;
        logic [3:0]  lanes;
        logic        mem_req;
        logic        bus;
        logic        junk;
        logic        got;
        logic        first;
        rng = xorshift(rng);
        o = pick_op(int'(rng % 11));
        k = rng[9:8];
        w = rng[15:10];
        junk = rng[16];
        t = writes_mem(o) ? STORE : (reads_mem(o) ? LOAD : ALU);
        if (rng[20:18] == 3'd0) begin
            t = ALU;    // Decoded as an ALU op
        end
        rng = xorshift(rng);
        sd = rng;
        rng = xorshift(rng);
        old = rng;

        lanes   = lane_mask(o, k);
        mem_req = (t == LOAD && reads_mem(o)) || (t == STORE && writes_mem(o));
        bus     = mem_req && lanes != 4'b0000;
        exp_mis = mem_req && lanes == 4'b0000;
        exp_result = old;
        if (bus && reads_mem(o)) begin
            exp_result = load_expect(o, k, shadow[w], old);
        end
        if (bus && writes_mem(o)) begin
            shadow[w] = store_expect(o, lanes, shadow[w], sd);
        end
        exp_adr    = {24'h000010, w, 2'b00};
        exp_sel    = lanes;
        exp_we     = writes_mem(o);
        exp_cycles = bus ? 1 : 0;
        chk_idx    = w;
        exp_word   = shadow[w];
        cyc_count  = 0;

        start      = 1'b1;
        op         = o;
        instr_type = t;
        addr       = {24'h000010, w, k};
        store_data = sd;
        reg_old    = old;

        first = 1'b1;
        got   = 1'b0;
        while (!got) begin
            @(posedge clk);
            #1;
            got = done;
            if (first && junk) begin
                rng        = xorshift(rng);    // Start while busy, must be ignored
                op         = pick_op(int'(rng % 11));
                instr_type = rng[4] ? LOAD : STORE;
                addr       = rng;
                store_data = ~rng;
            end else begin
                start = 1'b0;
            end
            first = 1'b0;
        end
        @(posedge clk);    // Done checks sample here
        #1;
        start = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (wb_cyc && !cyc_prev) begin
            cyc_count = cyc_count + 1;
            bus_total = bus_total + 1;
        end
        cyc_prev = wb_cyc;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: no finish after %0d cycles, %0d errors so far", cycles, errors);
            $display("test failed");
            $finish;
        end
    end

    a_adr: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && wb_stb) |-> wb_adr == exp_adr)
        else note_mismatch("wb_adr", exp_adr, $sampled(wb_adr));

    a_sel: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && wb_stb) |-> wb_sel == exp_sel)
        else note_mismatch("wb_sel", 32'(exp_sel), 32'($sampled(wb_sel)));

    a_we: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && wb_stb) |-> wb_we == exp_we)
        else note_mismatch("wb_we", 32'(exp_we), 32'($sampled(wb_we)));

    // Classic cycle, stb follows cyc
    a_stb: assert property (@(posedge clk) disable iff (rst)
        wb_stb == wb_cyc)
        else note_mismatch("wb_stb", 32'($sampled(wb_cyc)), 32'($sampled(wb_stb)));

    a_result: assert property (@(posedge clk) disable iff (rst)
        done |-> result == exp_result)
        else note_mismatch("result", exp_result, $sampled(result));

    a_mis: assert property (@(posedge clk) disable iff (rst)
        done |-> misaligned == exp_mis)
        else note_mismatch("misaligned", 32'(exp_mis), 32'($sampled(misaligned)));

    a_mis_done: assert property (@(posedge clk) disable iff (rst)
        misaligned |-> done)
        else note_failure("misaligned pulsed without done");

    a_cycles: assert property (@(posedge clk) disable iff (rst)
        done |-> cyc_count == exp_cycles)
        else note_failure("wrong number of bus cycles for one request");

    a_mem: assert property (@(posedge clk) disable iff (rst)
        done |-> mem_inst.mem[chk_idx] == exp_word)
        else note_mismatch("memory word", exp_word, mem_inst.mem[chk_idx]);

    a_reset: assert property (@(posedge clk)
        $fell(rst) |-> (!busy && !wb_cyc && !done))
        else note_failure("busy, cyc or done high right after reset");

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        op         = LW;
        instr_type = OTHER;
        addr       = '0;
        store_data = '0;
        reg_old    = '0;
        rng        = 32'h768ac3cc;
        errors     = 0;
        cycles     = 0;
        cyc_count  = 0;
        bus_total  = 0;
        cyc_prev   = 1'b0;
        exp_adr    = '0;
        exp_sel    = '0;
        exp_we     = 1'b0;
        exp_result = '0;
        exp_mis    = 1'b0;
        exp_cycles = 0;
        chk_idx    = '0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = 32'(i + 1) * 32'h9e37_79b9;    // Same fill as the slave
        end
        exp_word = shadow[0];
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int n = 0; n < N_REQ; n++) begin
            run_request();
        end
        $display("Requests %0d, bus cycles %0d, errors %0d", N_REQ, bus_total, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/wb_mem_model.sv */
`default_nettype none

`include "lsu_defines.svh"

module wb_mem_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`LSU_DATA_W-1:0] adr,
    input  logic [`LSU_BYTES-1:0]  sel,
    input  logic [`LSU_DATA_W-1:0] dat_w,
    output logic [`LSU_DATA_W-1:0] dat_r,
    output logic                   ack
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`LSU_DATA_W-1:0] mem [64];
    logic [31:0]            rng;
    logic [1:0]             wait_cnt;
    logic [1:0]             wait_len;
    logic [5:0]             idx;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign idx = adr[7:2];    // 64-word window

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'(i + 1) * 32'h9e37_79b9;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            ack      <= 1'b0;
            wait_cnt <= 2'd0;
            wait_len <= 2'd0;
            rng      <= 32'h768ac3cc;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (wait_cnt == wait_len) begin
                    ack      <= 1'b1;
                    dat_r    <= mem[idx];
                    wait_cnt <= 2'd0;
                    rng      <= xorshift(rng);
                    wait_len <= rng[1:0];    // Wait states for the next cycle
                    if (we) begin
                        for (int b = 0; b < `LSU_BYTES; b++) begin
                            if (sel[b]) begin
                                mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
                            end
                        end
                    end
                end else begin
                    wait_cnt <= wait_cnt + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mips_lsu.sv */
`default_nettype none

`include "lsu_defines.svh"

module mips_lsu (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  mips_isa_pkg::opcode_e     op,
    input  mips_isa_pkg::instr_type_e instr_type,
    input  logic [`LSU_DATA_W-1:0]    addr,
    input  logic [`LSU_DATA_W-1:0]    store_data,
    input  logic [`LSU_DATA_W-1:0]    reg_old,
    output logic                      busy,
    output logic                      done,
    output logic                      misaligned,
    output logic [`LSU_DATA_W-1:0]    result,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [`LSU_DATA_W-1:0]    wb_adr,
    output logic [`LSU_BYTES-1:0]     wb_sel,
    output logic [`LSU_DATA_W-1:0]    wb_dat_w,
    input  logic [`LSU_DATA_W-1:0]    wb_dat_r,
    input  logic                      wb_ack
);

    import mips_isa_pkg::*;

    opcode_e                op_q;
    instr_type_e            type_q;
    logic [`LSU_DATA_W-1:0] addr_q;
    logic [`LSU_DATA_W-1:0] store_data_q;
    logic [`LSU_DATA_W-1:0] reg_old_q;
    logic [`LSU_DATA_W-1:0] load_value;

    lsu_ctrl ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .op           (op),
        .instr_type   (instr_type),
        .addr         (addr),
        .store_data   (store_data),
        .reg_old      (reg_old),
        .byteenable   (wb_sel),
        .load_value   (load_value),
        .wb_ack       (wb_ack),
        .op_q         (op_q),
        .type_q       (type_q),
        .addr_q       (addr_q),
        .store_data_q (store_data_q),
        .reg_old_q    (reg_old_q),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .busy         (busy),
        .done         (done),
        .misaligned   (misaligned),
        .result       (result)
    );

    mips_cpu_memint memint_inst (
        .cpu_out    (addr_q),
        .op         (op_q),
        .instr_type (type_q),
        .mem_addr   (wb_adr),
        .byteenable (wb_sel)
    );

    lsu_store_align store_align_inst (
        .op         (op_q),
        .store_data (store_data_q),
        .wb_dat_w   (wb_dat_w)
    );

    lsu_load_merge load_merge_inst (
        .op         (op_q),
        .byte_idx   (addr_q[1:0]),
        .rd_word    (wb_dat_r),
        .reg_old    (reg_old_q),
        .load_value (load_value)
    );

endmodule

`default_nettype wire

/* hw/lsu_ctrl.sv */
`default_nettype none

`include "lsu_defines.svh"

module lsu_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  mips_isa_pkg::opcode_e     op,
    input  mips_isa_pkg::instr_type_e instr_type,
    input  logic [`LSU_DATA_W-1:0]    addr,
    input  logic [`LSU_DATA_W-1:0]    store_data,
    input  logic [`LSU_DATA_W-1:0]    reg_old,
    input  logic [`LSU_BYTES-1:0]     byteenable,
    input  logic [`LSU_DATA_W-1:0]    load_value,
    input  logic                      wb_ack,
    output mips_isa_pkg::opcode_e     op_q,
    output mips_isa_pkg::instr_type_e type_q,
    output logic [`LSU_DATA_W-1:0]    addr_q,
    output logic [`LSU_DATA_W-1:0]    store_data_q,
    output logic [`LSU_DATA_W-1:0]    reg_old_q,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic                      busy,
    output logic                      done,
    output logic                      misaligned,
    output logic [`LSU_DATA_W-1:0]    result
);

    import mips_isa_pkg::*;
    import lsu_bus_pkg::*;

    lsu_state_e             state;
    opcode_e                op_r;
    instr_type_e            type_r;
    logic [`LSU_DATA_W-1:0] addr_r;
    logic [`LSU_DATA_W-1:0] store_data_r;
    logic [`LSU_DATA_W-1:0] reg_old_r;
    logic                   is_store;
    logic                   is_load;
    logic                   mem_req;
    logic                   bad_lanes;
    logic                   accept;
    logic                   go_bus;

    // When idle the request goes straight through, so its lanes are known at accept
    assign op_q         = (state == IDLE) ? op : op_r;
    assign type_q       = (state == IDLE) ? instr_type : type_r;
    assign addr_q       = (state == IDLE) ? addr : addr_r;
    assign store_data_q = (state == IDLE) ? store_data : store_data_r;
    assign reg_old_q    = (state == IDLE) ? reg_old : reg_old_r;

    assign is_store  = op_is_store(op_q);
    assign is_load   = (op_size(op_q) != ACC_NONE) && !is_store;
    assign mem_req   = (type_q == LOAD && is_load) || (type_q == STORE && is_store);
    assign bad_lanes = (byteenable == `LSU_BE_NONE);
    assign go_bus    = mem_req && !bad_lanes;
    assign accept    = start && !busy;

    assign busy  = (state != IDLE);
    assign done  = (state == DONE);
    assign wb_we = wb_cyc && is_store;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_r         <= op;
            type_r       <= instr_type;
            addr_r       <= addr;
            store_data_r <= store_data;
            reg_old_r    <= reg_old;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            wb_cyc     <= 1'b0;
            wb_stb     <= 1'b0;
            misaligned <= 1'b0;
        end else begin
            misaligned <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= go_bus ? BUS : DONE;
                        wb_cyc     <= go_bus;
                        wb_stb     <= go_bus;
                        misaligned <= mem_req && bad_lanes;
                    end
                end
                BUS: begin
                    if (wb_ack) begin
                        state  <= DONE;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !go_bus) begin
            result <= reg_old_q;    // No bus cycle
        end else if (wb_cyc && wb_ack) begin
            result <= is_load ? load_value : reg_old_q;
        end
    end

    a_stb_with_cyc: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_stb) |-> wb_cyc);

    // Lanes come back from the decoder, so this covers the whole request path
    a_bus_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && !wb_ack) |=> ($stable(addr_q) && $stable(byteenable) && $stable(wb_we)));

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

endmodule

`default_nettype wire

/* hw/lsu_load_merge.sv */
`default_nettype none

`include "lsu_defines.svh"

module lsu_load_merge (
    input  mips_isa_pkg::opcode_e  op,
    input  logic [1:0]             byte_idx,
    input  logic [`LSU_DATA_W-1:0] rd_word,
    input  logic [`LSU_DATA_W-1:0] reg_old,
    output logic [`LSU_DATA_W-1:0] load_value
);

    import mips_isa_pkg::*;
    import lsu_bus_pkg::*;

    lsu_word_u             rd;
    lsu_word_u             old;
    lsu_word_u             merged;
    logic [7:0]            sel_byte;
    logic [15:0]           sel_half;
    logic [`LSU_BYTES-1:0] take_mem;

    assign rd       = rd_word;
    assign old      = reg_old;
    assign sel_byte = rd.lane[byte_idx];
    assign sel_half = rd.half[byte_idx[1]];    // Index is even here

    always_comb begin
        case (op)
            LWL:     take_mem = 4'b1111 << byte_idx;
            LWR:     take_mem = 4'b1111 >> (2'd3 - byte_idx);
            default: take_mem = '1;
        endcase
    end

    // Lanes not taken from memory keep the old register bytes
    always_comb begin
        for (int j = 0; j < `LSU_BYTES; j++) begin
            merged.lane[j] = take_mem[j] ? rd.lane[j] : old.lane[j];
        end
    end

    always_comb begin
        case (op)
            LB: begin
                load_value = {{24{sel_byte[7]}}, sel_byte};
            end
            LBU: begin
                load_value = {24'b0, sel_byte};
            end
            LH: begin
                load_value = {{16{sel_half[15]}}, sel_half};
            end
            LHU: begin
                load_value = {16'b0, sel_half};
            end
            LW: begin
                load_value = rd_word;
            end
            LWL, LWR: begin
                load_value = merged;
            end
            default: begin
                load_value = reg_old;    // Not a load
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/lsu_store_align.sv */
`default_nettype none

`include "lsu_defines.svh"

module lsu_store_align (
    input  mips_isa_pkg::opcode_e  op,
    input  logic [`LSU_DATA_W-1:0] store_data,
    output logic [`LSU_DATA_W-1:0] wb_dat_w
);

    import mips_isa_pkg::*;
    import lsu_bus_pkg::*;

    lsu_word_u src;
    lsu_word_u rep;

    assign src = store_data;

    // The slave picks the right copy through wb_sel
    always_comb begin
        rep = src;    // SW as is
        case (op)
            SB: begin
                for (int i = 0; i < `LSU_BYTES; i++) begin
                    rep.lane[i] = src.lane[0];
                end
            end
            SH: begin
                rep.half[0] = src.half[0];
                rep.half[1] = src.half[0];
            end
            default: begin
                rep = src;
            end
        endcase
    end

    assign wb_dat_w = rep;

endmodule

`default_nettype wire

/* hw/mips_cpu_memint.sv */
`default_nettype none

`include "lsu_defines.svh"

module mips_cpu_memint (
    input  logic [`LSU_DATA_W-1:0]    cpu_out,
    input  mips_isa_pkg::opcode_e     op,
    input  mips_isa_pkg::instr_type_e instr_type,
    output logic [`LSU_DATA_W-1:0]    mem_addr,
    output logic [`LSU_BYTES-1:0]     byteenable
);

    import mips_isa_pkg::*;

    logic [1:0]   byte_idx;
    access_size_e size;

    assign byte_idx = cpu_out[1:0];
    assign mem_addr = {cpu_out[`LSU_DATA_W-1:2], 2'b00};
    assign size     = op_size(op);

    always_comb begin
        if (instr_type == LOAD || instr_type == STORE) begin
            case (size)
                ACC_BYTE: begin
                    byteenable = 4'b0001 << byte_idx;
                end
                ACC_HALF: begin
                    if (byte_idx[0]) begin
                        byteenable = `LSU_BE_NONE;    // Odd halfword
                    end else begin
                        byteenable = 4'b0011 << byte_idx;
                    end
                end
                ACC_LEFT: begin
                    byteenable = 4'b1111 << byte_idx;    // Lanes k up to 3
                end
                ACC_RIGHT: begin
                    byteenable = 4'b1111 >> (2'd3 - byte_idx);    // Lanes 0 up to k
                end
                default: begin
                    byteenable = '1;    // Whole word, also LUI
                end
            endcase
        end else begin
            byteenable = '1;
        end
    end

endmodule

`default_nettype wire

/* hw/lsu_bus_pkg.sv */
`default_nettype none

`include "lsu_defines.svh"

package lsu_bus_pkg;

    // One bus word, seen as lanes or as halfwords
    typedef union packed {
        logic [`LSU_BYTES-1:0][7:0] lane;
        logic [1:0][15:0]           half;
    } lsu_word_u;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUS  = 2'd1,    // Wishbone cycle open
        DONE = 2'd2
    } lsu_state_e;

endpackage

`default_nettype wire

/* hw/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    typedef enum logic [5:0] {
        LB  = 6'b100000,
        LH  = 6'b100001,
        LWL = 6'b100010,
        LW  = 6'b100011,
        LBU = 6'b100100,
        LHU = 6'b100101,
        LWR = 6'b100110,
        SB  = 6'b101000,
        SH  = 6'b101001,
        SW  = 6'b101011,
        LUI = 6'b001111
    } opcode_e;

    typedef enum logic [1:0] {
        OTHER = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2,
        ALU   = 2'd3
    } instr_type_e;

    typedef enum logic [2:0] {
        ACC_NONE,
        ACC_BYTE,
        ACC_HALF,
        ACC_WORD,
        ACC_LEFT,
        ACC_RIGHT
    } access_size_e;

    function automatic access_size_e op_size(opcode_e op);
        case (op)
            LB, LBU, SB: return ACC_BYTE;
            LH, LHU, SH: return ACC_HALF;
            LW, SW:      return ACC_WORD;
            LWL:         return ACC_LEFT;
            LWR:         return ACC_RIGHT;
            default:     return ACC_NONE;    // LUI
        endcase
    endfunction

    function automatic logic op_is_store(opcode_e op);
        return op inside {SB, SH, SW};
    endfunction

endpackage

`default_nettype wire

/* include/lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data and address width
`define LSU_DATA_W 32

// Byte lanes per word
`define LSU_BYTES 4

// Lane pattern of an access that does not fit its word
`define LSU_BE_NONE 4'b0000

`endif
